// ==== src/axi_delay_pkg.sv ====
/*
  Shared AXI field widths and channel payload structs for the delay stage.
  Import with a wildcard in the module or interface header. Only ID, address,
  data, strobe, last and response fields are carried on this reduced link.
*/

package axi_delay_pkg;

  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;  // One strobe per byte
  localparam int unsigned RespWidth = 2;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [RespWidth-1:0] resp_t;  // OKAY, EXOKAY, SLVERR, DECERR

  // Write address beat, 20 bits
  typedef struct packed {
    id_t   id;
    addr_t addr;
  } aw_chan_t;

  // Write data beat, 37 bits
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // Write response, 6 bits
  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // Read address beat, 20 bits
  typedef struct packed {
    id_t   id;
    addr_t addr;
  } ar_chan_t;

  // Read data beat, 39 bits
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

endpackage

// ==== src/axi_bus_if.sv ====
/*
  One reduced AXI link with all five channels as struct plus valid/ready.
  Bind the slv modport on the subordinate-facing side of a block and the
  mst modport on the side that issues requests.
*/

`timescale 1ns/1ps

interface axi_bus_if
  import axi_delay_pkg::*;
();

  aw_chan_t aw;
  logic     aw_valid;
  logic     aw_ready;

  w_chan_t  w;
  logic     w_valid;
  logic     w_ready;

  b_chan_t  b;
  logic     b_valid;
  logic     b_ready;

  ar_chan_t ar;
  logic     ar_valid;
  logic     ar_ready;

  r_chan_t  r;
  logic     r_valid;
  logic     r_ready;

  // Accepts requests, returns responses
  modport slv (
    input  aw, aw_valid, w, w_valid, ar, ar_valid, b_ready, r_ready,
    output aw_ready, w_ready, ar_ready, b, b_valid, r, r_valid
  );

  // Issues requests, accepts responses
  modport mst (
    output aw, aw_valid, w, w_valid, ar, ar_valid, b_ready, r_ready,
    input  aw_ready, w_ready, ar_ready, b, b_valid, r, r_valid
  );

endinterface

// ==== src/stream_fifo_delay.sv ====
/*
  Order-preserving valid/ready buffer that holds every item for at least
  Delay cycles after it was accepted. Depth must be a power of two.
  The payload type is a parameter so one module serves every AXI channel.
*/

`timescale 1ns/1ps

module stream_fifo_delay #(
  parameter type         payload_t = logic,
  parameter int unsigned Delay     = 1,
  parameter int unsigned Depth     = 4   // Power of two
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t payload_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t payload_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);
  localparam int unsigned AgeW = (Delay > 0) ? $clog2(Delay + 1) : 1;
  localparam logic [AgeW-1:0] AgeMax  = AgeW'(Delay);
  localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);

  payload_t        mem [Depth];   // Circular store
  logic [AgeW-1:0] age [Depth];   // Cycles since each slot was written

  logic [PtrW-1:0] wr_ptr;
  logic [PtrW-1:0] rd_ptr;
  logic [CntW-1:0] count;
  logic            push;
  logic            pop;

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // Only the fill level decides, never ready_i
  assign ready_o = (count < CntW'(Depth));

  // Head leaves once it has aged enough
  assign valid_o   = (count != '0) && (age[rd_ptr] >= AgeMax);
  assign payload_o = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= payload_i;
    end
  end

  // Per-slot age, saturating at Delay
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < Depth; i++) begin
        age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < Depth; i++) begin
        if (push && (wr_ptr == PtrW'(i))) begin
          age[i] <= AgeW'(1);               // First cycle after acceptance
        end else if (age[i] < AgeMax) begin
          age[i] <= age[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LastPtr) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LastPtr) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither
      endcase
    end
  end

  // A stalled head keeps its offer until the far side takes it
  a_hold_stable : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(payload_o))
  ) else $error("Held output changed before transfer");

  // Upstream handshake never lands on a stored item
  a_no_write_full : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (push && (count != '0)) |-> (wr_ptr != rd_ptr)
  ) else $error("Write accepted while buffer full");

  // Pointers meet only when empty or full
  a_no_valid_empty : assert property (
    @(posedge clk_i) disable iff (rst_i)
    $rose(valid_o) |-> ((wr_ptr != rd_ptr) || (count == CntW'(Depth)))
  ) else $error("Output valid raised with empty buffer");

endmodule

// ==== src/axi_fifo_delay.sv ====
/*
  Delay stage for one AXI link. Each channel gets its own delay buffer, or
  a plain combinational path when its delay parameter is zero.
  Requests run from slv to mst, B and R responses run from mst to slv.
*/

`timescale 1ns/1ps

module axi_fifo_delay
  import axi_delay_pkg::*;
#(
  parameter int unsigned DelayAw = 0,
  parameter int unsigned DelayW  = 0,
  parameter int unsigned DelayB  = 0,
  parameter int unsigned DelayAr = 0,
  parameter int unsigned DelayR  = 0,
  parameter int unsigned DepthAw = 4,  // Power of two
  parameter int unsigned DepthW  = 4,
  parameter int unsigned DepthB  = 4,
  parameter int unsigned DepthAr = 4,
  parameter int unsigned DepthR  = 4
) (
  input logic    clk_i,
  input logic    rst_i,
  axi_bus_if.slv slv,
  axi_bus_if.mst mst
);

  if (DelayAw > 0) begin : gen_aw_delay
    stream_fifo_delay #(
      .payload_t ( aw_chan_t ),
      .Delay     ( DelayAw   ),
      .Depth     ( DepthAw   )
    ) i_aw_fifo_delay (
      .clk_i     ( clk_i        ),
      .rst_i     ( rst_i        ),
      .valid_i   ( slv.aw_valid ),
      .ready_o   ( slv.aw_ready ),
      .payload_i ( slv.aw       ),
      .valid_o   ( mst.aw_valid ),
      .ready_i   ( mst.aw_ready ),
      .payload_o ( mst.aw       )
    );
  end else begin : gen_aw_pass
    assign mst.aw       = slv.aw;
    assign mst.aw_valid = slv.aw_valid;
    assign slv.aw_ready = mst.aw_ready;
  end

  if (DelayW > 0) begin : gen_w_delay
    stream_fifo_delay #(
      .payload_t ( w_chan_t ),
      .Delay     ( DelayW   ),
      .Depth     ( DepthW   )
    ) i_w_fifo_delay (
      .clk_i     ( clk_i       ),
      .rst_i     ( rst_i       ),
      .valid_i   ( slv.w_valid ),
      .ready_o   ( slv.w_ready ),
      .payload_i ( slv.w       ),
      .valid_o   ( mst.w_valid ),
      .ready_i   ( mst.w_ready ),
      .payload_o ( mst.w       )
    );
  end else begin : gen_w_pass
    assign mst.w       = slv.w;
    assign mst.w_valid = slv.w_valid;
    assign slv.w_ready = mst.w_ready;
  end

  // Write response, subordinate back to manager
  if (DelayB > 0) begin : gen_b_delay
    stream_fifo_delay #(
      .payload_t ( b_chan_t ),
      .Delay     ( DelayB   ),
      .Depth     ( DepthB   )
    ) i_b_fifo_delay (
      .clk_i     ( clk_i       ),
      .rst_i     ( rst_i       ),
      .valid_i   ( mst.b_valid ),
      .ready_o   ( mst.b_ready ),
      .payload_i ( mst.b       ),
      .valid_o   ( slv.b_valid ),
      .ready_i   ( slv.b_ready ),
      .payload_o ( slv.b       )
    );
  end else begin : gen_b_pass
    assign slv.b       = mst.b;
    assign slv.b_valid = mst.b_valid;
    assign mst.b_ready = slv.b_ready;
  end

  if (DelayAr > 0) begin : gen_ar_delay
    stream_fifo_delay #(
      .payload_t ( ar_chan_t ),
      .Delay     ( DelayAr   ),
      .Depth     ( DepthAr   )
    ) i_ar_fifo_delay (
      .clk_i     ( clk_i        ),
      .rst_i     ( rst_i        ),
      .valid_i   ( slv.ar_valid ),
      .ready_o   ( slv.ar_ready ),
      .payload_i ( slv.ar       ),
      .valid_o   ( mst.ar_valid ),
      .ready_i   ( mst.ar_ready ),
      .payload_o ( mst.ar       )
    );
  end else begin : gen_ar_pass
    assign mst.ar       = slv.ar;
    assign mst.ar_valid = slv.ar_valid;
    assign slv.ar_ready = mst.ar_ready;
  end

  // Read data, subordinate back to manager
  if (DelayR > 0) begin : gen_r_delay
    stream_fifo_delay #(
      .payload_t ( r_chan_t ),
      .Delay     ( DelayR   ),
      .Depth     ( DepthR   )
    ) i_r_fifo_delay (
      .clk_i     ( clk_i       ),
      .rst_i     ( rst_i       ),
      .valid_i   ( mst.r_valid ),
      .ready_o   ( mst.r_ready ),
      .payload_i ( mst.r       ),
      .valid_o   ( slv.r_valid ),
      .ready_i   ( slv.r_ready ),
      .payload_o ( slv.r       )
    );
  end else begin : gen_r_pass
    assign slv.r       = mst.r;
    assign slv.r_valid = mst.r_valid;
    assign mst.r_ready = slv.r_ready;
  end

endmodule

// ==== src/axi_delay_top.sv ====
/*
  Top level of the AXI latency-injection stage with flat ports.
  The s_ ports face the manager, the m_ ports face the subordinate.
  Per-channel delays and buffer depths are set here and passed down.
*/

`timescale 1ns/1ps

module axi_delay_top
  import axi_delay_pkg::*;
#(
  parameter int unsigned DelayAw = 2,
  parameter int unsigned DelayW  = 0,  // W passes straight through
  parameter int unsigned DelayB  = 1,
  parameter int unsigned DelayAr = 3,
  parameter int unsigned DelayR  = 4,
  parameter int unsigned DepthAw = 4,
  parameter int unsigned DepthW  = 4,
  parameter int unsigned DepthB  = 4,
  parameter int unsigned DepthAr = 4,
  parameter int unsigned DepthR  = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Slave side, towards the manager
  input  logic [IdWidth-1:0]   s_aw_id_i,
  input  logic [AddrWidth-1:0] s_aw_addr_i,
  input  logic                 s_aw_valid_i,
  output logic                 s_aw_ready_o,
  input  logic [DataWidth-1:0] s_w_data_i,
  input  logic [StrbWidth-1:0] s_w_strb_i,
  input  logic                 s_w_last_i,
  input  logic                 s_w_valid_i,
  output logic                 s_w_ready_o,
  output logic [IdWidth-1:0]   s_b_id_o,
  output logic [RespWidth-1:0] s_b_resp_o,
  output logic                 s_b_valid_o,
  input  logic                 s_b_ready_i,
  input  logic [IdWidth-1:0]   s_ar_id_i,
  input  logic [AddrWidth-1:0] s_ar_addr_i,
  input  logic                 s_ar_valid_i,
  output logic                 s_ar_ready_o,
  output logic [IdWidth-1:0]   s_r_id_o,
  output logic [DataWidth-1:0] s_r_data_o,
  output logic [RespWidth-1:0] s_r_resp_o,
  output logic                 s_r_last_o,
  output logic                 s_r_valid_o,
  input  logic                 s_r_ready_i,
  // Master side, towards the subordinate
  output logic [IdWidth-1:0]   m_aw_id_o,
  output logic [AddrWidth-1:0] m_aw_addr_o,
  output logic                 m_aw_valid_o,
  input  logic                 m_aw_ready_i,
  output logic [DataWidth-1:0] m_w_data_o,
  output logic [StrbWidth-1:0] m_w_strb_o,
  output logic                 m_w_last_o,
  output logic                 m_w_valid_o,
  input  logic                 m_w_ready_i,
  input  logic [IdWidth-1:0]   m_b_id_i,
  input  logic [RespWidth-1:0] m_b_resp_i,
  input  logic                 m_b_valid_i,
  output logic                 m_b_ready_o,
  output logic [IdWidth-1:0]   m_ar_id_o,
  output logic [AddrWidth-1:0] m_ar_addr_o,
  output logic                 m_ar_valid_o,
  input  logic                 m_ar_ready_i,
  input  logic [IdWidth-1:0]   m_r_id_i,
  input  logic [DataWidth-1:0] m_r_data_i,
  input  logic [RespWidth-1:0] m_r_resp_i,
  input  logic                 m_r_last_i,
  input  logic                 m_r_valid_i,
  output logic                 m_r_ready_o
);

  axi_bus_if bus_slv ();
  axi_bus_if bus_mst ();

  // Manager-facing port packed into bus_slv
  assign bus_slv.aw       = '{id: s_aw_id_i, addr: s_aw_addr_i};
  assign bus_slv.aw_valid = s_aw_valid_i;
  assign s_aw_ready_o     = bus_slv.aw_ready;
  assign bus_slv.w        = '{data: s_w_data_i, strb: s_w_strb_i, last: s_w_last_i};
  assign bus_slv.w_valid  = s_w_valid_i;
  assign s_w_ready_o      = bus_slv.w_ready;
  assign s_b_id_o         = bus_slv.b.id;
  assign s_b_resp_o       = bus_slv.b.resp;
  assign s_b_valid_o      = bus_slv.b_valid;
  assign bus_slv.b_ready  = s_b_ready_i;
  assign bus_slv.ar       = '{id: s_ar_id_i, addr: s_ar_addr_i};
  assign bus_slv.ar_valid = s_ar_valid_i;
  assign s_ar_ready_o     = bus_slv.ar_ready;
  assign s_r_id_o         = bus_slv.r.id;
  assign s_r_data_o       = bus_slv.r.data;
  assign s_r_resp_o       = bus_slv.r.resp;
  assign s_r_last_o       = bus_slv.r.last;
  assign s_r_valid_o      = bus_slv.r_valid;
  assign bus_slv.r_ready  = s_r_ready_i;

  // Subordinate-facing port unpacked from bus_mst
  assign m_aw_id_o        = bus_mst.aw.id;
  assign m_aw_addr_o      = bus_mst.aw.addr;
  assign m_aw_valid_o     = bus_mst.aw_valid;
  assign bus_mst.aw_ready = m_aw_ready_i;
  assign m_w_data_o       = bus_mst.w.data;
  assign m_w_strb_o       = bus_mst.w.strb;
  assign m_w_last_o       = bus_mst.w.last;
  assign m_w_valid_o      = bus_mst.w_valid;
  assign bus_mst.w_ready  = m_w_ready_i;
  assign bus_mst.b        = '{id: m_b_id_i, resp: m_b_resp_i};
  assign bus_mst.b_valid  = m_b_valid_i;
  assign m_b_ready_o      = bus_mst.b_ready;
  assign m_ar_id_o        = bus_mst.ar.id;
  assign m_ar_addr_o      = bus_mst.ar.addr;
  assign m_ar_valid_o     = bus_mst.ar_valid;
  assign bus_mst.ar_ready = m_ar_ready_i;
  assign bus_mst.r        = '{id: m_r_id_i, data: m_r_data_i, resp: m_r_resp_i,
                              last: m_r_last_i};
  assign bus_mst.r_valid  = m_r_valid_i;
  assign m_r_ready_o      = bus_mst.r_ready;

  axi_fifo_delay #(
    .DelayAw ( DelayAw ),
    .DelayW  ( DelayW  ),
    .DelayB  ( DelayB  ),
    .DelayAr ( DelayAr ),
    .DelayR  ( DelayR  ),
    .DepthAw ( DepthAw ),
    .DepthW  ( DepthW  ),
    .DepthB  ( DepthB  ),
    .DepthAr ( DepthAr ),
    .DepthR  ( DepthR  )
  ) i_axi_delayer (
    .clk_i ( clk_i   ),
    .rst_i ( rst_i   ),
    .slv   ( bus_slv ),
    .mst   ( bus_mst )
  );

endmodule

// ==== bench/axi_delay_checker.sv ====
/*
  Scoreboard for the AXI delay stage. Keeps a queue of accepted beats with
  their acceptance cycle for each channel and checks payload, order, latency
  and output hold at the far port. The testbench top calls its tasks to
  close each test and reads err_cnt at the end.
*/

`timescale 1ns/1ps

module axi_delay_checker
  import axi_delay_pkg::*;
(
  input logic                 clk_i,
  input logic                 rst_i,
  input logic [IdWidth-1:0]   s_aw_id_i, s_b_id_o, s_ar_id_i, s_r_id_o,
  input logic [IdWidth-1:0]   m_aw_id_o, m_b_id_i, m_ar_id_o, m_r_id_i,
  input logic [AddrWidth-1:0] s_aw_addr_i, s_ar_addr_i, m_aw_addr_o, m_ar_addr_o,
  input logic [DataWidth-1:0] s_w_data_i, s_r_data_o, m_w_data_o, m_r_data_i,
  input logic [StrbWidth-1:0] s_w_strb_i, m_w_strb_o,
  input logic [RespWidth-1:0] s_b_resp_o, s_r_resp_o, m_b_resp_i, m_r_resp_i,
  input logic                 s_w_last_i, s_r_last_o, m_w_last_o, m_r_last_i,
  input logic                 s_aw_valid_i, s_w_valid_i, s_b_valid_o, s_ar_valid_i,
  input logic                 s_r_valid_o, m_aw_valid_o, m_w_valid_o, m_b_valid_i,
  input logic                 m_ar_valid_o, m_r_valid_i,
  input logic                 s_aw_ready_o, s_w_ready_o, s_b_ready_i, s_ar_ready_o,
  input logic                 s_r_ready_i, m_aw_ready_i, m_w_ready_i, m_b_ready_o,
  input logic                 m_ar_ready_i, m_r_ready_o
);

  // Channel index 0 to 4 is AW, W, B, AR, R
  string       port_name [5] = '{"m_aw", "m_w", "s_b", "m_ar", "s_r"};
  int unsigned ch_delay  [5] = '{2, 0, 1, 3, 4};

  logic [95:0] beat_q [5][$];   // {acceptance cycle, payload}
  logic        held    [5];     // Offered last edge without transfer
  logic [63:0] held_pl [5];
  int unsigned cycle     = 0;
  bit          exact     = 1'b0;  // Latency must equal the delay
  int unsigned err_cnt   = 0;
  int unsigned test_err  = 0;
  int unsigned test_num  = 0;
  int unsigned test_fail = 0;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic track(input int ch, input logic in_hs, input logic [63:0] in_pl,
                       input logic out_v, input logic out_r, input logic [63:0] out_pl);
    logic [95:0] head;
    int unsigned lat;
    if (in_hs) begin
      beat_q[ch].push_back({cycle, in_pl});
    end
    if (held[ch] && !(out_v && out_pl === held_pl[ch])) begin
      report_failure($sformatf("%s dropped valid or changed payload before transfer",
                               port_name[ch]));
    end
    held[ch]    = out_v && !out_r;
    held_pl[ch] = out_pl;
    if (out_v && out_r) begin
      if (beat_q[ch].size() == 0) begin
        report_failure($sformatf("%s delivered a beat that was never accepted",
                                 port_name[ch]));
      end else begin
        head = beat_q[ch].pop_front();
        lat  = cycle - head[95:64];
        if (head[63:0] !== out_pl) begin
          $display("Mismatch %s payload: expected 0x%h, got 0x%h",
                   port_name[ch], head[63:0], out_pl);
          err_cnt++;
        end
        if (lat < ch_delay[ch] || (exact && lat != ch_delay[ch])) begin
          report_failure($sformatf("%s beat left %0d cycles after acceptance, delay is %0d",
                                   port_name[ch], lat, ch_delay[ch]));
        end
      end
    end
  endtask

  // Sampled at the edge, so both sides show their pre-edge values
  always @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 5; i++) begin
        held[i] = 1'b0;
      end
    end else begin
      track(0, s_aw_valid_i && s_aw_ready_o, 64'({s_aw_id_i, s_aw_addr_i}),
            m_aw_valid_o, m_aw_ready_i, 64'({m_aw_id_o, m_aw_addr_o}));
      track(1, s_w_valid_i && s_w_ready_o, 64'({s_w_data_i, s_w_strb_i, s_w_last_i}),
            m_w_valid_o, m_w_ready_i, 64'({m_w_data_o, m_w_strb_o, m_w_last_o}));
      track(2, m_b_valid_i && m_b_ready_o, 64'({m_b_id_i, m_b_resp_i}),
            s_b_valid_o, s_b_ready_i, 64'({s_b_id_o, s_b_resp_o}));
      track(3, s_ar_valid_i && s_ar_ready_o, 64'({s_ar_id_i, s_ar_addr_i}),
            m_ar_valid_o, m_ar_ready_i, 64'({m_ar_id_o, m_ar_addr_o}));
      track(4, m_r_valid_i && m_r_ready_o,
            64'({m_r_id_i, m_r_data_i, m_r_resp_i, m_r_last_i}), s_r_valid_o, s_r_ready_i,
            64'({s_r_id_o, s_r_data_o, s_r_resp_o, s_r_last_o}));
    end
    cycle = cycle + 1;
  end

  function automatic int unsigned pending();
    int unsigned total;
    total = 0;
    for (int i = 0; i < 5; i++) begin
      total += beat_q[i].size();
    end
    return total;
  endfunction

  task automatic set_exact(input bit on);
    exact = on;
  endtask

  // Delayed channels only, pass-through W follows its far side
  task automatic check_idle();
    expect_bit("s_aw_ready_o", s_aw_ready_o, 1'b1);
    expect_bit("s_ar_ready_o", s_ar_ready_o, 1'b1);
    expect_bit("m_b_ready_o", m_b_ready_o, 1'b1);
    expect_bit("m_r_ready_o", m_r_ready_o, 1'b1);
    expect_bit("m_aw_valid_o", m_aw_valid_o, 1'b0);
    expect_bit("m_ar_valid_o", m_ar_valid_o, 1'b0);
    expect_bit("s_b_valid_o", s_b_valid_o, 1'b0);
    expect_bit("s_r_valid_o", s_r_valid_o, 1'b0);
  endtask

  task automatic check_aw_full(input int unsigned n);
    expect_bit("s_aw_ready_o", s_aw_ready_o, 1'b0);
    if (beat_q[0].size() != n) begin
      $display("Mismatch AW beats held: expected 0x%h, got 0x%h", n, beat_q[0].size());
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (err_cnt == test_err) begin
      $display("Test %0d, %s: ok", test_num, name);
    end else begin
      test_fail++;
      $display("Test %0d, %s: %0d errors", test_num, name, err_cnt - test_err);
    end
    test_err = err_cnt;
  endtask

  task automatic summary();
    $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
             test_num, test_num - test_fail, test_fail, err_cnt);
  endtask

endmodule

// ==== bench/tb_axi_delay.sv ====
/*
  Testbench for the AXI delay stage. Drives random beats into both ports
  from a fixed seed, with random ready back-pressure on both sides.
  The checker module i_chk models every channel and counts the errors.
*/

`timescale 1ns/1ps

module tb_axi_delay
  import axi_delay_pkg::*;
();

  localparam int unsigned TimeoutCycles = 500;
  localparam int unsigned StressCycles  = 400;

  logic                 clk_i;
  logic                 rst_i;
  logic [IdWidth-1:0]   s_aw_id_i, s_b_id_o, s_ar_id_i, s_r_id_o;
  logic [IdWidth-1:0]   m_aw_id_o, m_b_id_i, m_ar_id_o, m_r_id_i;
  logic [AddrWidth-1:0] s_aw_addr_i, s_ar_addr_i, m_aw_addr_o, m_ar_addr_o;
  logic [DataWidth-1:0] s_w_data_i, s_r_data_o, m_w_data_o, m_r_data_i;
  logic [StrbWidth-1:0] s_w_strb_i, m_w_strb_o;
  logic [RespWidth-1:0] s_b_resp_o, s_r_resp_o, m_b_resp_i, m_r_resp_i;
  logic                 s_w_last_i, s_r_last_o, m_w_last_o, m_r_last_i;
  logic                 s_aw_valid_i, s_w_valid_i, s_b_valid_o, s_ar_valid_i, s_r_valid_o;
  logic                 m_aw_valid_o, m_w_valid_o, m_b_valid_i, m_ar_valid_o, m_r_valid_i;
  logic                 s_aw_ready_o, s_w_ready_o, s_b_ready_i, s_ar_ready_o, s_r_ready_i;
  logic                 m_aw_ready_i, m_w_ready_i, m_b_ready_o, m_ar_ready_i, m_r_ready_o;

  integer seed;
  bit     stress;    // Random ready on both ports
  bit     dense;     // New beat in every free cycle
  bit     aw_block;  // Far AW ready held low

  axi_delay_top i_dut (.*);

  axi_delay_checker i_chk (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic rand_bit();
    return ($random(seed) & 1) != 0;
  endfunction

  // Runs right after a rising edge and sees the handshakes of that edge
  task automatic drive_cycle(input logic [4:0] new_mask);
    if (!s_aw_valid_i || s_aw_ready_o) begin
      s_aw_valid_i <= new_mask[0] && (dense || rand_bit());
      s_aw_id_i    <= IdWidth'($random(seed));
      s_aw_addr_i  <= AddrWidth'($random(seed));
    end
    if (!s_w_valid_i || s_w_ready_o) begin
      s_w_valid_i <= new_mask[1] && (dense || rand_bit());
      s_w_data_i  <= DataWidth'($random(seed));
      s_w_strb_i  <= StrbWidth'($random(seed));
      s_w_last_i  <= rand_bit();
    end
    if (!m_b_valid_i || m_b_ready_o) begin
      m_b_valid_i <= new_mask[2] && (dense || rand_bit());
      m_b_id_i    <= IdWidth'($random(seed));
      m_b_resp_i  <= RespWidth'($random(seed));
    end
    if (!s_ar_valid_i || s_ar_ready_o) begin
      s_ar_valid_i <= new_mask[3] && (dense || rand_bit());
      s_ar_id_i    <= IdWidth'($random(seed));
      s_ar_addr_i  <= AddrWidth'($random(seed));
    end
    if (!m_r_valid_i || m_r_ready_o) begin
      m_r_valid_i <= new_mask[4] && (dense || rand_bit());
      m_r_id_i    <= IdWidth'($random(seed));
      m_r_data_i  <= DataWidth'($random(seed));
      m_r_resp_i  <= RespWidth'($random(seed));
      m_r_last_i  <= rand_bit();
    end
    s_b_ready_i  <= !stress || rand_bit();
    s_r_ready_i  <= !stress || rand_bit();
    m_w_ready_i  <= !stress || rand_bit();
    m_ar_ready_i <= !stress || rand_bit();
    m_aw_ready_i <= !aw_block && (!stress || rand_bit());
  endtask

  // No new beats, far readies high, until sources and DUT are empty
  task automatic wait_drain(input string what);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (i_chk.pending() != 0 || s_aw_valid_i || s_w_valid_i || s_ar_valid_i ||
           m_b_valid_i || m_r_valid_i) begin
      if (n == TimeoutCycles) begin
        i_chk.report_failure($sformatf("Timeout: %s did not drain in %0d cycles", what, n));
        return;
      end
      @(posedge clk_i);
      drive_cycle(5'b00000);
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic fill_aw();
    int unsigned n;
    n        = 0;
    aw_block = 1'b1;
    dense    = 1'b1;
    do begin
      @(posedge clk_i);
      drive_cycle(5'b00001);
      @(negedge clk_i);
      n++;
    end while (s_aw_ready_o && n < TimeoutCycles);
    if (s_aw_ready_o) begin
      i_chk.report_failure("Timeout: AW buffer never dropped its ready");
    end
    repeat (3) begin  // Stays full while the next beat waits
      @(posedge clk_i);
      drive_cycle(5'b00001);
    end
    @(negedge clk_i);
    i_chk.check_aw_full(4);
    aw_block = 1'b0;
    dense    = 1'b0;
  endtask

  initial begin
    seed     = 30;
    stress   = 1'b0;
    dense    = 1'b0;
    aw_block = 1'b0;
    rst_i        <= 1'b1;
    s_aw_valid_i <= 1'b0;
    s_aw_id_i    <= '0;
    s_aw_addr_i  <= '0;
    s_w_valid_i  <= 1'b0;
    s_w_data_i   <= '0;
    s_w_strb_i   <= '0;
    s_w_last_i   <= 1'b0;
    s_ar_valid_i <= 1'b0;
    s_ar_id_i    <= '0;
    s_ar_addr_i  <= '0;
    m_b_valid_i  <= 1'b0;
    m_b_id_i     <= '0;
    m_b_resp_i   <= '0;
    m_r_valid_i  <= 1'b0;
    m_r_id_i     <= '0;
    m_r_data_i   <= '0;
    m_r_resp_i   <= '0;
    m_r_last_i   <= 1'b0;
    s_b_ready_i  <= 1'b1;
    s_r_ready_i  <= 1'b1;
    m_aw_ready_i <= 1'b1;
    m_w_ready_i  <= 1'b1;
    m_ar_ready_i <= 1'b1;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    i_chk.check_idle();
    i_chk.end_test("idle state after reset");

    // One beat on every channel at once
    i_chk.set_exact(1'b1);
    dense = 1'b1;
    @(posedge clk_i);
    drive_cycle(5'b11111);
    dense = 1'b0;
    wait_drain("single beat");
    i_chk.set_exact(1'b0);
    i_chk.end_test("single beat latency");

    stress = 1'b1;
    repeat (StressCycles) begin
      @(posedge clk_i);
      drive_cycle(5'b11111);
    end
    stress = 1'b0;
    wait_drain("random traffic");
    i_chk.end_test("random traffic with back-pressure");

    fill_aw();
    wait_drain("AW fill");
    i_chk.end_test("AW buffer fill and drain");

    i_chk.summary();
    if (i_chk.err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
src/axi_delay_pkg.sv
src/axi_bus_if.sv
src/stream_fifo_delay.sv
src/axi_fifo_delay.sv
src/axi_delay_top.sv
bench/axi_delay_checker.sv
bench/tb_axi_delay.sv

// ==== Bender.yml ====
package:
  name: axi_delay

sources:
  - src/axi_delay_pkg.sv
  - src/axi_bus_if.sv
  - src/stream_fifo_delay.sv
  - src/axi_fifo_delay.sv
  - src/axi_delay_top.sv
  - target: test
    files:
      - bench/axi_delay_checker.sv
      - bench/tb_axi_delay.sv
